/* flist.f */
+incdir+verilog
verilog/sq_store_pkg.sv
verilog/sq_load_pkg.sv
verilog/sq_entry_array.sv
verilog/sq_match_select.sv
verilog/sq_forward.sv
verilog/sq_retire.sv
verilog/sq_top.sv
test/sq_properties.sv
test/sq_tb.sv

/* test/sq_properties.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_properties import sq_store_pkg::*, sq_load_pkg::*; (
  input logic      clk,
  input logic      rst,
  input logic      flush,
  input logic      retire,
  input ld_req_t   ld_req,
  input ld_resp_t  ld_resp,
  input mem_wr_t   mem_wr,
  input sq_entry_t head_entry
);

  int fail_cnt = 0;

  reset_idle: assert property (@(posedge clk) rst |=> !ld_resp.valid && !mem_wr.valid)
    else begin
      $error("output valid after a reset edge");
      fail_cnt++;
    end

  // only a complete head store may retire
  retire_legal: assert property (@(posedge clk) disable iff (rst)
    retire |-> head_entry.valid && head_entry.data_valid)
    else begin
      $error("retire without a complete head entry");
      fail_cnt++;
    end

  resp_follows: assert property (@(posedge clk) disable iff (rst)
    ld_req.valid && !flush |=> ld_resp.valid)
    else begin
      $error("load check gave no response");
      fail_cnt++;
    end

  resp_only_after_req: assert property (@(posedge clk) disable iff (rst)
    !(ld_req.valid && !flush) |=> !ld_resp.valid)
    else begin
      $error("load response without a load check");
      fail_cnt++;
    end

endmodule

bind sq_top sq_properties i_sq_properties (
  .clk        (clk),
  .rst        (rst),
  .flush      (flush),
  .retire     (retire),
  .ld_req     (ld_req),
  .ld_resp    (ld_resp),
  .mem_wr     (mem_wr),
  .head_entry (head_entry)
);

/* test/sq_tb.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_tb import sq_store_pkg::*, sq_load_pkg::*; ();

  // reset, directed checks, one fill and drain of the whole queue, flush
  localparam int PLAN_CYCLES    = 120;
  localparam int TIMEOUT_CYCLES = 2 * PLAN_CYCLES;

  logic      clk;
  logic      rst;
  st_write_t st_wr;
  st_data_t  st_upd;
  ld_req_t   ld_req;
  logic      retire;
  logic      flush;
  ld_resp_t  ld_resp;
  mem_wr_t   mem_wr;

  logic [`SQ_ADDR_W-1:0] m_addr [`SQ_DEPTH];  // reference queue
  logic [`SQ_BYTES-1:0]  m_mask [`SQ_DEPTH];
  logic [`SQ_DATA_W-1:0] m_data [`SQ_DEPTH];
  logic                  m_valid [`SQ_DEPTH];
  logic                  m_dvalid [`SQ_DEPTH];
  int                    m_head;
  int                    alloc;               // next index handed out
  ld_resp_t              pend_ld;
  ld_resp_t              exp_ld;
  mem_wr_t               pend_mem;
  mem_wr_t               exp_mem;
  logic                  chk_en;
  int                    err_count = 0;
  int                    cycle_cnt = 0;
  logic [`SQ_ADDR_W-1:0] addr_a;
  logic [`SQ_ADDR_W-1:0] addr_b;

  sq_top i_sq_top (.clk, .rst, .st_wr, .st_upd, .ld_req, .retire, .flush, .ld_resp, .mem_wr);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // youngest overlapping store between head and the load's tail
  function automatic ld_resp_t ref_load(ld_req_t r);
    ld_resp_t res;
    logic     hit;
    int       sel;
    int       span;
    int       e;
    res  = '0;
    hit  = 1'b0;
    sel  = 0;
    span = (int'(r.tail) - m_head + `SQ_DEPTH) % `SQ_DEPTH;
    for (int k = 0; k < span; k++) begin
      e = (m_head + k) % `SQ_DEPTH;
      if (m_valid[e] && m_addr[e] == r.addr && (m_mask[e] & r.mask) != '0) begin
        hit = 1'b1;
        sel = e;
      end
    end
    res.valid  = r.valid && !flush;
    res.result = ld_miss;
    if (hit && (m_mask[sel] & r.mask) == r.mask && m_dvalid[sel]) begin
      res.result = ld_forward;
      res.data   = m_data[sel];
      res.idx    = `SQ_IDX_W'(sel);
    end else if (hit) begin
      res.result = ld_stall;
    end
    return res;
  endfunction

  function automatic mem_wr_t ref_mem();
    mem_wr_t w;
    w = '0;
    if (retire && !flush && m_valid[m_head] && m_dvalid[m_head]) begin
      w.valid = 1'b1;
      w.addr  = m_addr[m_head];
      w.mask  = m_mask[m_head];
      w.data  = m_data[m_head];
    end
    return w;
  endfunction

  // state after the coming clock edge
  task automatic update_model();
    logic upd_ok;
    upd_ok = st_upd.valid && m_valid[st_upd.idx];
    if (flush) begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
        m_valid[i]  = 1'b0;
        m_dvalid[i] = 1'b0;
      end
      m_head = 0;
    end else begin
      if (retire && m_valid[m_head] && m_dvalid[m_head]) begin
        m_valid[m_head]  = 1'b0;
        m_dvalid[m_head] = 1'b0;
        m_head = (m_head + 1) % `SQ_DEPTH;
      end
      if (st_wr.valid) begin
        m_valid[st_wr.idx]  = 1'b1;
        m_dvalid[st_wr.idx] = 1'b0;
        m_addr[st_wr.idx]   = st_wr.addr;
        m_mask[st_wr.idx]   = st_wr.mask;
      end
      if (upd_ok) begin
        m_dvalid[st_upd.idx] = 1'b1;
        m_data[st_upd.idx]   = st_upd.data;
      end
    end
  endtask

  task automatic tick();
    pend_ld  = ref_load(ld_req);
    pend_mem = ref_mem();
    update_model();
    @(negedge clk);
    st_wr  = '0;
    st_upd = '0;
    ld_req = '0;
    retire = 1'b0;
    flush  = 1'b0;
  endtask

  task automatic put_load(logic [`SQ_ADDR_W-1:0] a, logic [`SQ_BYTES-1:0] m, int t);
    ld_req.valid = 1'b1;
    ld_req.addr  = a;
    ld_req.mask  = m;
    ld_req.tail  = `SQ_IDX_W'(t);
  endtask

  task automatic put_random_load();
    int inflight;
    inflight = (alloc - m_head + `SQ_DEPTH) % `SQ_DEPTH;
    put_load(($urandom % 2) ? addr_a : addr_b, `SQ_BYTES'($urandom % 15 + 1),
             (m_head + $urandom % (inflight + 1)) % `SQ_DEPTH);
  endtask

  task automatic put_data(int idx);
    st_upd.valid = 1'b1;
    st_upd.idx   = `SQ_IDX_W'(idx);
    st_upd.data  = $urandom;
  endtask

  // address write, then data one cycle later with a random load beside it
  task automatic new_store(logic [`SQ_ADDR_W-1:0] a, logic [`SQ_BYTES-1:0] m, logic with_data);
    st_wr.valid = 1'b1;
    st_wr.idx   = `SQ_IDX_W'(alloc);
    st_wr.addr  = a;
    st_wr.mask  = m;
    tick();
    if (with_data) begin
      put_data(alloc);
    end
    put_random_load();
    tick();
    alloc = (alloc + 1) % `SQ_DEPTH;
  endtask

  task automatic retire_one();
    if (!m_dvalid[m_head]) begin
      put_data(m_head);  // head needs data before it may leave
      tick();
    end
    retire = 1'b1;
    put_random_load();
    tick();
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      err_count++;
    end
  endtask

  always @(posedge clk) begin
    exp_ld    <= pend_ld;
    exp_mem   <= pend_mem;
    chk_en    <= !rst;
    cycle_cnt <= cycle_cnt + 1;
  end

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (chk_en) begin
      check_val("ld_resp.valid", ld_resp.valid, exp_ld.valid);
      if (exp_ld.valid) begin
        check_val("ld_resp.result", ld_resp.result, exp_ld.result);
        check_val("ld_resp.data", ld_resp.data, exp_ld.data);
        check_val("ld_resp.idx", ld_resp.idx, exp_ld.idx);
      end
      check_val("mem_wr.valid", mem_wr.valid, exp_mem.valid);
      if (exp_mem.valid) begin
        check_val("mem_wr.addr", mem_wr.addr, exp_mem.addr);
        check_val("mem_wr.mask", mem_wr.mask, exp_mem.mask);
        check_val("mem_wr.data", mem_wr.data, exp_mem.data);
      end
    end
  end

  initial begin
    wait (cycle_cnt == TIMEOUT_CYCLES);
    $display("timeout: test did not reach its end within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h480c_cb5a));
    rst      = 1'b1;
    st_wr    = '0;
    st_upd   = '0;
    ld_req   = '0;
    retire   = 1'b0;
    flush    = 1'b0;
    pend_ld  = '0;
    pend_mem = '0;
    chk_en   = 1'b0;
    m_head   = 0;
    alloc    = 0;
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      m_valid[i]  = 1'b0;
      m_dvalid[i] = 1'b0;
    end
    addr_a = `SQ_ADDR_W'($urandom);
    addr_b = addr_a ^ `SQ_ADDR_W'(1);
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (4) tick();  // idle, nothing valid
    new_store(addr_a, 4'hf, 1'b1);
    new_store(addr_a, 4'hf, 1'b1);
    new_store(addr_b, 4'hf, 1'b1);
    new_store(addr_a, 4'hc, 1'b1);
    put_load(addr_a, 4'h3, 1);
    tick();
    put_load(addr_a, 4'h3, 4);  // hits entry 1 as entry 3 shares no byte
    tick();
    put_load(addr_a, 4'hf, 4);  // entry 3 covers part only
    tick();
    put_load(addr_a, 4'h4, 4);
    tick();
    put_load(addr_a, 4'h3, 0);  // tail at head
    tick();
    put_load(addr_a ^ `SQ_ADDR_W'(2), 4'hf, 4);
    tick();
    new_store(addr_a, 4'hf, 1'b0);
    put_load(addr_a, 4'h1, 5);  // data pending
    tick();
    put_data(4);
    tick();
    put_load(addr_a, 4'h1, 5);
    tick();
    repeat (3) retire_one();
    put_load(addr_a, 4'hf, 5);
    tick();
    put_load(addr_a, 4'h3, 2);  // window wraps over retired entries 0 and 1
    tick();
    repeat (2) retire_one();
    // full queue across the index wrap
    repeat (`SQ_DEPTH - 1) begin
      new_store(($urandom % 2) ? addr_a : addr_b, `SQ_BYTES'($urandom % 15 + 1),
                ($urandom % 4) != 0);
    end
    while (m_head != alloc) begin
      retire_one();
    end
    new_store(addr_a, 4'hf, 1'b1);
    retire = 1'b1;
    flush  = 1'b1;
    put_load(addr_a, 4'hf, alloc);
    tick();
    alloc = 0;
    put_load(addr_a, 4'hf, 5);
    tick();
    new_store(addr_a, 4'hf, 1'b1);
    put_load(addr_a, 4'hf, 1);
    tick();
    retire_one();
    repeat (4) tick();
    $display("errors: %0d compare, %0d assertion", err_count,
             i_sq_top.i_sq_properties.fail_cnt);
    if (err_count == 0 && i_sq_top.i_sq_properties.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog/sq_defs.svh */
`ifndef SQ_DEFS_SVH
`define SQ_DEFS_SVH

// store queue sizing

// number of store entries
`define SQ_DEPTH 16

// entry index, log2 of depth
`define SQ_IDX_W 4

// word address, byte offset already dropped
`define SQ_ADDR_W 30

// one data word
`define SQ_DATA_W 32

// bytes per word, one mask bit each
`define SQ_BYTES 4

`endif

/* verilog/sq_entry_array.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_entry_array import sq_store_pkg::*; (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                flush,
  input  st_write_t                           st_wr,
  input  st_data_t                            st_upd,
  input  logic                                free_en,
  input  logic [`SQ_IDX_W-1:0]                head,
  output sq_entry_t [`SQ_DEPTH-1:0]           entries,
  output sq_entry_t                           head_entry
);

  logic [`SQ_DEPTH-1:0]  vld;
  logic [`SQ_DEPTH-1:0]  dvld;
  logic [`SQ_ADDR_W-1:0] addr_q [`SQ_DEPTH];
  logic [`SQ_BYTES-1:0]  mask_q [`SQ_DEPTH];
  logic [`SQ_DATA_W-1:0] data_q [`SQ_DEPTH];

  // valid state per entry
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      vld  <= '0;
      dvld <= '0;
    end else begin
      for (int i = 0; i < `SQ_DEPTH; i++) begin
        if (free_en && head == `SQ_IDX_W'(i)) begin
          vld[i]  <= 1'b0;
          dvld[i] <= 1'b0;
        end
        // new address, data still to come
        if (st_wr.valid && st_wr.idx == `SQ_IDX_W'(i)) begin
          vld[i]  <= 1'b1;
          dvld[i] <= 1'b0;
        end
        if (st_upd.valid && st_upd.idx == `SQ_IDX_W'(i) && vld[i]) begin
          dvld[i] <= 1'b1;
        end
      end
    end
  end

  // payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      if (st_wr.valid && st_wr.idx == `SQ_IDX_W'(i)) begin
        addr_q[i] <= st_wr.addr;
        mask_q[i] <= st_wr.mask;
      end
      if (st_upd.valid && st_upd.idx == `SQ_IDX_W'(i)) begin
        data_q[i] <= st_upd.data;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      entries[i].valid      = vld[i];
      entries[i].data_valid = dvld[i];
      entries[i].addr       = addr_q[i];
      entries[i].mask       = mask_q[i];
      entries[i].data       = data_q[i];
    end
  end

  assign head_entry = entries[head];  // oldest store

endmodule

/* verilog/sq_forward.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_forward import sq_store_pkg::*, sq_load_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  ld_req_t              ld_req,
  input  logic                 sel_hit,
  input  sq_entry_t            sel_entry,
  input  logic [`SQ_IDX_W-1:0] sel_idx,
  output ld_resp_t             ld_resp
);

  logic                  covers;
  ld_result_e            nxt_result;
  logic [`SQ_DATA_W-1:0] nxt_data;
  logic [`SQ_IDX_W-1:0]  nxt_idx;

  assign covers = (sel_entry.mask & ld_req.mask) == ld_req.mask;

  always_comb begin
    nxt_result = ld_miss;
    nxt_data   = '0;
    nxt_idx    = '0;
    if (sel_hit) begin
      if (covers && sel_entry.data_valid) begin
        nxt_result = ld_forward;
        nxt_data   = sel_entry.data;
        nxt_idx    = sel_idx;
      end else begin
        nxt_result = ld_stall;  // partial cover or data pending
      end
    end
  end

  always_ff @(posedge clk) begin
    ld_resp.result <= nxt_result;
    ld_resp.data   <= nxt_data;
    ld_resp.idx    <= nxt_idx;
    if (rst || flush) begin
      ld_resp.valid <= 1'b0;
    end else begin
      ld_resp.valid <= ld_req.valid;
    end
  end

endmodule

/* verilog/sq_load_pkg.sv */
`include "sq_defs.svh"

package sq_load_pkg;

  typedef enum logic [1:0] {
    ld_miss    = 2'd0,
    ld_forward = 2'd1,
    ld_stall   = 2'd2
  } ld_result_e;

  // load check, tail is the first entry younger than the load
  typedef struct packed {
    logic                  valid;
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_BYTES-1:0]  mask;
    logic [`SQ_IDX_W-1:0]  tail;
  } ld_req_t;

  typedef struct packed {
    logic                  valid;
    ld_result_e            result;
    logic [`SQ_DATA_W-1:0] data;  // zero unless forward
    logic [`SQ_IDX_W-1:0]  idx;
  } ld_resp_t;

endpackage

/* verilog/sq_match_select.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_match_select import sq_store_pkg::*, sq_load_pkg::*; (
  input  sq_entry_t [`SQ_DEPTH-1:0] entries,
  input  logic [`SQ_IDX_W-1:0]      head,
  input  ld_req_t                   ld_req,
  output logic                      sel_hit,
  output sq_entry_t                 sel_entry,
  output logic [`SQ_IDX_W-1:0]      sel_idx
);

  logic [`SQ_DEPTH-1:0]   match;
  logic [2*`SQ_DEPTH-1:0] match_dbl;
  logic [`SQ_DEPTH-1:0]   rot_match;  // bit 0 is head
  logic [`SQ_IDX_W-1:0]   win_len;
  logic [`SQ_IDX_W-1:0]   sel_off;

  // same word, at least one common byte
  always_comb begin
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      match[i] = entries[i].valid && entries[i].addr == ld_req.addr &&
                 |(entries[i].mask & ld_req.mask);
    end
  end

  assign match_dbl = {match, match} >> head;
  assign rot_match = match_dbl[`SQ_DEPTH-1:0];
  assign win_len   = ld_req.tail - head;  // stores older than the load

  // last hit inside the window is the youngest
  always_comb begin
    sel_hit = 1'b0;
    sel_off = '0;
    for (int k = 0; k < `SQ_DEPTH; k++) begin
      if (rot_match[k] && `SQ_IDX_W'(k) < win_len) begin
        sel_hit = 1'b1;
        sel_off = `SQ_IDX_W'(k);
      end
    end
  end

  assign sel_idx   = head + sel_off;
  assign sel_entry = entries[sel_idx];

endmodule

/* verilog/sq_retire.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_retire import sq_store_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 retire,
  input  sq_entry_t            head_entry,
  output logic [`SQ_IDX_W-1:0] head,
  output logic                 free_en,
  output mem_wr_t              mem_wr
);

  // only a complete head store leaves the queue
  assign free_en = retire && !flush && head_entry.valid && head_entry.data_valid;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head <= '0;
    end else if (free_en) begin
      if (head == `SQ_IDX_W'(`SQ_DEPTH - 1)) begin
        head <= '0;
      end else begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    mem_wr.addr <= head_entry.addr;
    mem_wr.mask <= head_entry.mask;
    mem_wr.data <= head_entry.data;
    if (rst) begin
      mem_wr.valid <= 1'b0;
    end else begin
      mem_wr.valid <= free_en;  // one cycle, not held
    end
  end

endmodule

/* verilog/sq_store_pkg.sv */
`include "sq_defs.svh"

package sq_store_pkg;

  // one queued store
  typedef struct packed {
    logic                  valid;
    logic                  data_valid;  // set by data update
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_BYTES-1:0]  mask;
    logic [`SQ_DATA_W-1:0] data;
  } sq_entry_t;

  // address write from the store pipe
  typedef struct packed {
    logic                  valid;
    logic [`SQ_IDX_W-1:0]  idx;
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_BYTES-1:0]  mask;
  } st_write_t;

  typedef struct packed {
    logic                  valid;
    logic [`SQ_IDX_W-1:0]  idx;
    logic [`SQ_DATA_W-1:0] data;
  } st_data_t;

  // retired store towards memory
  typedef struct packed {
    logic                  valid;
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_BYTES-1:0]  mask;
    logic [`SQ_DATA_W-1:0] data;
  } mem_wr_t;

endpackage

/* verilog/sq_top.sv */
`timescale 1ns/1ps
`include "sq_defs.svh"

module sq_top import sq_store_pkg::*, sq_load_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  st_write_t st_wr,
  input  st_data_t  st_upd,
  input  ld_req_t   ld_req,
  input  logic      retire,
  input  logic      flush,
  output ld_resp_t  ld_resp,
  output mem_wr_t   mem_wr
);

  sq_entry_t [`SQ_DEPTH-1:0] entries;
  sq_entry_t                 head_entry;
  sq_entry_t                 sel_entry;
  logic [`SQ_IDX_W-1:0]      head;
  logic [`SQ_IDX_W-1:0]      sel_idx;
  logic                      free_en;
  logic                      sel_hit;

  sq_entry_array i_sq_entry_array (
    .clk, .rst, .flush, .st_wr, .st_upd, .free_en, .head,
    .entries, .head_entry
  );

  // combinational search, registered in sq_forward
  sq_match_select i_sq_match_select (
    .entries, .head, .ld_req,
    .sel_hit, .sel_entry, .sel_idx
  );

  sq_forward i_sq_forward (
    .clk, .rst, .flush, .ld_req, .sel_hit, .sel_entry, .sel_idx,
    .ld_resp
  );

  sq_retire i_sq_retire (
    .clk, .rst, .flush, .retire, .head_entry,
    .head, .free_en, .mem_wr
  );

endmodule
